//--- source/fifo_pkg.sv
package fifo_pkg;

   // ----------------------------------------
   // fifo geometry
   // ----------------------------------------

   // number of entries in the external memory
   localparam int FIFO_DEPTH = 16;

   // memory address width
   localparam int ADDR_W = $clog2(FIFO_DEPTH);

   // fill count has to reach FIFO_DEPTH itself
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   // ----------------------------------------
   // status thresholds
   // ----------------------------------------

   // almost full at or above this fill level
   localparam int AFULL_LEVEL = 13;

   // almost empty at or below this fill level
   localparam int AEMPTY_LEVEL = 3;

   // ----------------------------------------
   // vector types
   // ----------------------------------------

   // write or read address into the memory
   typedef logic [ADDR_W-1:0] addr_t;

   // number of entries currently held
   typedef logic [CNT_W-1:0] count_t;

endpackage

//--- source/fifo_access_ctrl.sv
`timescale 1ns/1ps

module fifo_access_ctrl (
   input  logic pos_clk,
   input  logic aresetn,

   // raw request strobes
   input  logic we_i,
   input  logic re_i,

   // registered status from the occupancy tracker
   input  logic full_i,
   input  logic empty_i,

   // accepted requests, same cycle as the request
   output logic wr_accept_o,
   output logic rd_accept_o,

   // strobes one cycle after the request
   output logic wack_o,
   output logic dvld_o,
   output logic overflow_o,
   output logic underflow_o
);

   // ----------------------------------------
   // request decode
   // ----------------------------------------

   // requests that hit a full or empty fifo
   logic wr_refused;
   logic rd_refused;

   // write goes through unless full
   assign wr_accept_o = we_i & ~full_i;

   // read goes through unless empty
   assign rd_accept_o = re_i & ~empty_i;

   // refused requests are dropped and only reported
   assign wr_refused = we_i & full_i;
   assign rd_refused = re_i & empty_i;

   // ----------------------------------------
   // write side strobes
   // ----------------------------------------

   // acknowledge of an accepted write
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wack_o <= 1'b0;
      end else begin
         wack_o <= wr_accept_o;
      end
   end

   // write attempted while full
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         overflow_o <= 1'b0;
      end else begin
         overflow_o <= wr_refused;
      end
   end

   // ----------------------------------------
   // read side strobes
   // ----------------------------------------

   // memory data is valid the cycle after the read strobe
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         dvld_o <= 1'b0;
      end else begin
         dvld_o <= rd_accept_o;
      end
   end

   // read attempted while empty
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         underflow_o <= 1'b0;
      end else begin
         underflow_o <= rd_refused;
      end
   end

endmodule

//--- source/fifo_addr_ctr.sv
`timescale 1ns/1ps

module fifo_addr_ctr (
   input  logic            pos_clk,
   input  logic            aresetn,

   // advance by one entry
   input  logic            step_i,

   // current memory address
   output fifo_pkg::addr_t addr_o
);

   // ----------------------------------------
   // next address
   // ----------------------------------------

   // highest valid memory location
   localparam fifo_pkg::addr_t LAST_ADDR = fifo_pkg::addr_t'(fifo_pkg::FIFO_DEPTH - 1);

   fifo_pkg::addr_t addr_d;
   logic            at_last;

   // explicit compare so odd depths wrap too
   assign at_last = (addr_o == LAST_ADDR);

   always_comb begin
      addr_d = addr_o;
      if (step_i) begin
         if (at_last) begin
            addr_d = '0;
         end else begin
            addr_d = addr_o + fifo_pkg::addr_t'(1);
         end
      end
   end

   // ----------------------------------------
   // address register
   // ----------------------------------------

   // moves on the same edge that samples the strobe
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         addr_o <= '0;
      end else begin
         addr_o <= addr_d;
      end
   end

endmodule

//--- source/fifo_occupancy.sv
`timescale 1ns/1ps

module fifo_occupancy (
   input  logic             pos_clk,
   input  logic             aresetn,

   // accepted requests from the control
   input  logic             wr_accept_i,
   input  logic             rd_accept_i,

   // number of entries held
   output fifo_pkg::count_t count_o,

   // registered status flags
   output logic             full_o,
   output logic             afull_o,
   output logic             empty_o,
   output logic             aempty_o
);

   // ----------------------------------------
   // level constants
   // ----------------------------------------

   // compare values sized to the count
   localparam fifo_pkg::count_t FULL_CNT   = fifo_pkg::count_t'(fifo_pkg::FIFO_DEPTH);
   localparam fifo_pkg::count_t AFULL_CNT  = fifo_pkg::count_t'(fifo_pkg::AFULL_LEVEL);
   localparam fifo_pkg::count_t AEMPTY_CNT = fifo_pkg::count_t'(fifo_pkg::AEMPTY_LEVEL);

   // ----------------------------------------
   // next count
   // ----------------------------------------

   fifo_pkg::count_t count_d;

   // next flag values
   logic full_d;
   logic afull_d;
   logic empty_d;
   logic aempty_d;

   // accepts are already gated, so no range check here
   always_comb begin
      case ({wr_accept_i, rd_accept_i})
         2'b10: begin
            count_d = count_o + fifo_pkg::count_t'(1);
         end
         2'b01: begin
            count_d = count_o - fifo_pkg::count_t'(1);
         end
         default: begin
            // idle, or write and read cancel out
            count_d = count_o;
         end
      endcase
   end

   // ----------------------------------------
   // flag decode
   // ----------------------------------------

   // flags follow the next count so they line up with count_o
   always_comb begin
      full_d   = (count_d == FULL_CNT);
      empty_d  = (count_d == '0);
      afull_d  = (count_d >= AFULL_CNT);
      aempty_d = (count_d <= AEMPTY_CNT);
   end

   // ----------------------------------------
   // count register
   // ----------------------------------------

   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         count_o <= '0;
      end else begin
         count_o <= count_d;
      end
   end

   // ----------------------------------------
   // flag registers
   // ----------------------------------------

   // full side, both low out of reset
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         full_o  <= 1'b0;
         afull_o <= 1'b0;
      end else begin
         full_o  <= full_d;
         afull_o <= afull_d;
      end
   end

   // empty side, both high out of reset
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         empty_o  <= 1'b1;
         aempty_o <= 1'b1;
      end else begin
         empty_o  <= empty_d;
         aempty_o <= aempty_d;
      end
   end

endmodule

//--- source/fifo_sync_top.sv
`timescale 1ns/1ps

module fifo_sync_top (
   input  logic           pos_clk,
   input  logic           aresetn,

   // request strobes from the user side
   input  logic           we_i,
   input  logic           re_i,

   // external memory port
   output logic           mem_we_o,
   output logic           mem_re_o,
   output fifo_pkg::addr_t mem_waddr_o,
   output fifo_pkg::addr_t mem_raddr_o,

   // status flags
   output logic           full_o,
   output logic           afull_o,
   output logic           empty_o,
   output logic           aempty_o,
   output fifo_pkg::count_t count_o,

   // handshake and error strobes
   output logic           wack_o,
   output logic           dvld_o,
   output logic           overflow_o,
   output logic           underflow_o
);

   // ----------------------------------------
   // internal nets
   // ----------------------------------------

   // accepted requests, one cycle wide
   logic wr_accept;
   logic rd_accept;

   // ----------------------------------------
   // request control
   // ----------------------------------------

   // gates requests against the registered flags
   fifo_access_ctrl u_ctrl (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .we_i        (we_i),
      .re_i        (re_i),
      .full_i      (full_o),
      .empty_i     (empty_o),
      .wr_accept_o (wr_accept),
      .rd_accept_o (rd_accept),
      .wack_o      (wack_o),
      .dvld_o      (dvld_o),
      .overflow_o  (overflow_o),
      .underflow_o (underflow_o)
   );

   // ----------------------------------------
   // memory address counters
   // ----------------------------------------

   // write side steps on accepted writes
   fifo_addr_ctr u_waddr (
      .pos_clk (pos_clk),
      .aresetn (aresetn),
      .step_i  (wr_accept),
      .addr_o  (mem_waddr_o)
   );

   // read side steps on accepted reads
   fifo_addr_ctr u_raddr (
      .pos_clk (pos_clk),
      .aresetn (aresetn),
      .step_i  (rd_accept),
      .addr_o  (mem_raddr_o)
   );

   // ----------------------------------------
   // fill level and flags
   // ----------------------------------------

   fifo_occupancy u_occ (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .wr_accept_i (wr_accept),
      .rd_accept_i (rd_accept),
      .count_o     (count_o),
      .full_o      (full_o),
      .afull_o     (afull_o),
      .empty_o     (empty_o),
      .aempty_o    (aempty_o)
   );

   // memory strobes are the accepts themselves
   assign mem_we_o = wr_accept;
   assign mem_re_o = rd_accept;

endmodule

//--- dv/fifo_checker.sv
`timescale 1ns/1ps

module fifo_checker (
   input  logic             pos_clk,
   input  logic             aresetn,
   input  logic             we_i,
   input  logic             re_i,
   input  logic             mem_we_i,
   input  logic             mem_re_i,
   input  fifo_pkg::addr_t  mem_waddr_i,
   input  fifo_pkg::addr_t  mem_raddr_i,
   input  logic             full_i,
   input  logic             afull_i,
   input  logic             empty_i,
   input  logic             aempty_i,
   input  fifo_pkg::count_t count_i,
   input  logic             wack_i,
   input  logic             dvld_i,
   input  logic             overflow_i,
   input  logic             underflow_i,
   output int               errors_o
);

   // sample point, a quarter period after the falling edge
   localparam int SETTLE = 25;

   // ----------------------------------------
   // reference model state
   // ----------------------------------------

   fifo_pkg::count_t m_count;
   fifo_pkg::addr_t  m_waddr;
   fifo_pkg::addr_t  m_raddr;
   logic             m_full;
   logic             m_afull;
   logic             m_empty;
   logic             m_aempty;
   logic             m_wack;
   logic             m_dvld;
   logic             m_ovf;
   logic             m_udf;
   int               mismatches;

   assign errors_o = mismatches;

   // wraps after the last memory entry
   function automatic fifo_pkg::addr_t next_addr(input fifo_pkg::addr_t a);
      if (int'(a) == fifo_pkg::FIFO_DEPTH - 1) begin
         return '0;
      end
      return fifo_pkg::addr_t'(int'(a) + 1);
   endfunction

   // one clock edge of the fifo, from the sampled requests
   function automatic void ref_step(
      input  logic             we,
      input  logic             re,
      inout  fifo_pkg::count_t cnt,
      inout  fifo_pkg::addr_t  waddr,
      inout  fifo_pkg::addr_t  raddr,
      inout  logic             full,
      inout  logic             afull,
      inout  logic             empty,
      inout  logic             aempty,
      output logic             wack,
      output logic             dvld,
      output logic             ovf,
      output logic             udf
   );
      logic wr_ok;
      logic rd_ok;
      int   level;
      wr_ok = we && !full;
      rd_ok = re && !empty;
      // refused requests only show up as error strobes
      wack  = wr_ok;
      dvld  = rd_ok;
      ovf   = we && full;
      udf   = re && empty;
      level = int'(cnt) + (wr_ok ? 1 : 0) - (rd_ok ? 1 : 0);
      cnt   = fifo_pkg::count_t'(level);
      if (wr_ok) begin
         waddr = next_addr(waddr);
      end
      if (rd_ok) begin
         raddr = next_addr(raddr);
      end
      // flags follow the new level
      full   = (level == fifo_pkg::FIFO_DEPTH);
      empty  = (level == 0);
      afull  = (level >= fifo_pkg::AFULL_LEVEL);
      aempty = (level <= fifo_pkg::AEMPTY_LEVEL);
   endfunction

   // values expected right after reset
   task automatic reset_model();
      m_count  = '0;
      m_waddr  = '0;
      m_raddr  = '0;
      m_full   = 1'b0;
      m_afull  = 1'b0;
      m_empty  = 1'b1;
      m_aempty = 1'b1;
      m_wack   = 1'b0;
      m_dvld   = 1'b0;
      m_ovf    = 1'b0;
      m_udf    = 1'b0;
   endtask

   // ----------------------------------------
   // comparison
   // ----------------------------------------

   task automatic compare(input string name, input logic [7:0] exp, input logic [7:0] act);
      if (exp !== act) begin
         mismatches++;
         $display("** Error at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
      end
   endtask

   task automatic check_outputs();
      compare("count_o", 8'(m_count), 8'(count_i));
      compare("mem_waddr_o", 8'(m_waddr), 8'(mem_waddr_i));
      compare("mem_raddr_o", 8'(m_raddr), 8'(mem_raddr_i));
      compare("full_o", 8'(m_full), 8'(full_i));
      compare("afull_o", 8'(m_afull), 8'(afull_i));
      compare("empty_o", 8'(m_empty), 8'(empty_i));
      compare("aempty_o", 8'(m_aempty), 8'(aempty_i));
      compare("wack_o", 8'(m_wack), 8'(wack_i));
      compare("dvld_o", 8'(m_dvld), 8'(dvld_i));
      compare("overflow_o", 8'(m_ovf), 8'(overflow_i));
      compare("underflow_o", 8'(m_udf), 8'(underflow_i));
      // memory strobes follow the current requests
      compare("mem_we_o", 8'(we_i && !m_full), 8'(mem_we_i));
      compare("mem_re_o", 8'(re_i && !m_empty), 8'(mem_re_i));
   endtask

   // inputs changed on the falling edge and registers on the rising edge,
   // so everything is stable at this point
   initial begin
      mismatches = 0;
      reset_model();
      forever begin
         @(negedge pos_clk);
         #(SETTLE);
         if (!aresetn) begin
            reset_model();
            check_outputs();
         end else begin
            check_outputs();
            ref_step(we_i, re_i, m_count, m_waddr, m_raddr, m_full, m_afull,
                     m_empty, m_aempty, m_wack, m_dvld, m_ovf, m_udf);
         end
      end
   end

endmodule

//--- dv/tb_fifo_sync.sv
`timescale 1ns/1ps

module tb_fifo_sync;

   localparam int CLK_PERIOD   = 100;
   localparam int LEVEL_TMO    = 40;
   localparam int RAND_CYCLES  = 500;
   localparam fifo_pkg::addr_t TOP_ADDR = fifo_pkg::addr_t'(fifo_pkg::FIFO_DEPTH - 1);

   // low from time zero, so the first falling edge is a real one
   logic             pos_clk = 1'b0;
   logic             aresetn;
   logic             we_i;
   logic             re_i;
   logic             mem_we_o;
   logic             mem_re_o;
   fifo_pkg::addr_t  mem_waddr_o;
   fifo_pkg::addr_t  mem_raddr_o;
   logic             full_o;
   logic             afull_o;
   logic             empty_o;
   logic             aempty_o;
   fifo_pkg::count_t count_o;
   logic             wack_o;
   logic             dvld_o;
   logic             overflow_o;
   logic             underflow_o;

   // error bookkeeping
   int          chk_errors;
   int          own_errors;
   int          test_start;
   int          tests_run;
   int          tests_failed;
   logic [31:0] lfsr;
   logic        wr_bit;
   logic        rd_bit;

   // ----------------------------------------
   // clock, DUT and checker
   // ----------------------------------------

   initial begin
      forever begin
         #(CLK_PERIOD / 2) pos_clk = ~pos_clk;
      end
   end

   fifo_sync_top fifo_sync_top_i (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .we_i        (we_i),
      .re_i        (re_i),
      .mem_we_o    (mem_we_o),
      .mem_re_o    (mem_re_o),
      .mem_waddr_o (mem_waddr_o),
      .mem_raddr_o (mem_raddr_o),
      .full_o      (full_o),
      .afull_o     (afull_o),
      .empty_o     (empty_o),
      .aempty_o    (aempty_o),
      .count_o     (count_o),
      .wack_o      (wack_o),
      .dvld_o      (dvld_o),
      .overflow_o  (overflow_o),
      .underflow_o (underflow_o)
   );

   fifo_checker chk (
      .pos_clk     (pos_clk),
      .aresetn     (aresetn),
      .we_i        (we_i),
      .re_i        (re_i),
      .mem_we_i    (mem_we_o),
      .mem_re_i    (mem_re_o),
      .mem_waddr_i (mem_waddr_o),
      .mem_raddr_i (mem_raddr_o),
      .full_i      (full_o),
      .afull_i     (afull_o),
      .empty_i     (empty_o),
      .aempty_i    (aempty_o),
      .count_i     (count_o),
      .wack_i      (wack_o),
      .dvld_i      (dvld_o),
      .overflow_i  (overflow_o),
      .underflow_i (underflow_o),
      .errors_o    (chk_errors)
   );

   // ----------------------------------------
   // helpers
   // ----------------------------------------

   // galois form, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   task automatic drive_inputs(input logic we, input logic re);
      @(negedge pos_clk);
      we_i = we;
      re_i = re;
   endtask

   task automatic expect_value(input string name, input logic [7:0] exp, input logic [7:0] act);
      if (exp !== act) begin
         own_errors++;
         $display("** Error at %0d ns: %s expected %0h, got %0h", $time, name, exp, act);
      end
   endtask

   task automatic report_failure(input string msg);
      own_errors++;
      $display("failure at %0d ns: %s", $time, msg);
   endtask

   task automatic open_test();
      test_start = chk_errors + own_errors;
   endtask

   // two idle cycles let the checker see the last responses
   task automatic close_test(input string name);
      int errs;
      drive_inputs(1'b0, 1'b0);
      drive_inputs(1'b0, 1'b0);
      errs = chk_errors + own_errors - test_start;
      tests_run++;
      if (errs != 0) begin
         tests_failed++;
      end
      $display("test %-8s %s (%0d errors)", name, (errs == 0) ? "ok" : "FAILED", errs);
   endtask

   // ----------------------------------------
   // directed sequences
   // ----------------------------------------

   task automatic fill_fifo();
      int cycles;
      cycles = 0;
      @(negedge pos_clk);
      while (!full_o && cycles < LEVEL_TMO) begin
         we_i = 1'b1;
         re_i = 1'b0;
         @(negedge pos_clk);
         cycles++;
      end
      we_i = 1'b0;
      if (!full_o) begin
         report_failure("full_o did not rise within the fill timeout");
      end else begin
         expect_value("count_o", 8'(fifo_pkg::FIFO_DEPTH), 8'(count_o));
         expect_value("afull_o", 8'(1), 8'(afull_o));
      end
      // one write too many
      drive_inputs(1'b1, 1'b0);
      drive_inputs(1'b0, 1'b0);
      expect_value("overflow_o", 8'(1), 8'(overflow_o));
      expect_value("count_o", 8'(fifo_pkg::FIFO_DEPTH), 8'(count_o));
      expect_value("mem_waddr_o", 8'(0), 8'(mem_waddr_o));
   endtask

   task automatic drain_fifo();
      int cycles;
      cycles = 0;
      @(negedge pos_clk);
      while (!empty_o && cycles < LEVEL_TMO) begin
         we_i = 1'b0;
         re_i = 1'b1;
         @(negedge pos_clk);
         cycles++;
      end
      re_i = 1'b0;
      if (!empty_o) begin
         report_failure("empty_o did not rise within the drain timeout");
      end else begin
         expect_value("count_o", 8'(0), 8'(count_o));
         expect_value("aempty_o", 8'(1), 8'(aempty_o));
      end
      // one read too many
      drive_inputs(1'b0, 1'b1);
      drive_inputs(1'b0, 1'b0);
      expect_value("underflow_o", 8'(1), 8'(underflow_o));
      expect_value("count_o", 8'(0), 8'(count_o));
      expect_value("mem_raddr_o", 8'(0), 8'(mem_raddr_o));
   endtask

   // keeps a few entries and streams through both counters
   task automatic wrap_addresses();
      fifo_pkg::addr_t prev_w;
      fifo_pkg::addr_t prev_r;
      logic            saw_wwrap;
      logic            saw_rwrap;
      saw_wwrap = 1'b0;
      saw_rwrap = 1'b0;
      repeat (5) begin
         drive_inputs(1'b1, 1'b0);
      end
      repeat (20) begin
         prev_w = mem_waddr_o;
         prev_r = mem_raddr_o;
         drive_inputs(1'b1, 1'b1);
         if (prev_w == TOP_ADDR && mem_waddr_o == '0) begin
            saw_wwrap = 1'b1;
         end
         if (prev_r == TOP_ADDR && mem_raddr_o == '0) begin
            saw_rwrap = 1'b1;
         end
      end
      if (!saw_wwrap) begin
         report_failure("write address never wrapped from the last entry to 0");
      end
      if (!saw_rwrap) begin
         report_failure("read address never wrapped from the last entry to 0");
      end
   endtask

   // ----------------------------------------
   // test sequence
   // ----------------------------------------

   initial begin
      aresetn      = 1'b0;
      we_i         = 1'b0;
      re_i         = 1'b0;
      own_errors   = 0;
      test_start   = 0;
      tests_run    = 0;
      tests_failed = 0;
      lfsr         = 32'h47b7465e;

      open_test();
      repeat (4) begin
         @(negedge pos_clk);
      end
      aresetn = 1'b1;
      expect_value("empty_o", 8'(1), 8'(empty_o));
      expect_value("count_o", 8'(0), 8'(count_o));
      close_test("reset");

      open_test();
      fill_fifo();
      close_test("fill");

      open_test();
      drain_fifo();
      close_test("drain");

      open_test();
      wrap_addresses();
      close_test("wrap");

      // one lfsr step per request bit
      open_test();
      repeat (RAND_CYCLES) begin
         lfsr   = lfsr_next(lfsr);
         wr_bit = lfsr[0];
         lfsr   = lfsr_next(lfsr);
         rd_bit = lfsr[0];
         drive_inputs(wr_bit, rd_bit);
      end
      close_test("random");

      $display("tests run %0d, passed %0d, failed %0d, checker mismatches %0d",
               tests_run, tests_run - tests_failed, tests_failed, chk_errors);
      if (tests_failed == 0 && chk_errors == 0 && own_errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- flist.f
source/fifo_pkg.sv
source/fifo_access_ctrl.sv
source/fifo_addr_ctr.sv
source/fifo_occupancy.sv
source/fifo_sync_top.sv
dv/fifo_checker.sv
dv/tb_fifo_sync.sv

//--- Makefile
# Verilator flow for the synchronous FIFO controller

VERILATOR ?= verilator
TOP       ?= tb_fifo_sync
RTL_TOP   ?= fifo_sync_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= Test completed successfully

RTL_SRCS  ?= source/fifo_pkg.sv \
             source/fifo_access_ctrl.sv \
             source/fifo_addr_ctr.sv \
             source/fifo_occupancy.sv \
             source/fifo_sync_top.sv

SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

# design alone, then design with testbench
lint:
	$(VERILATOR) --lint-only $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# status comes from the search for the pass line
sim: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	if echo "$$out" | grep -qxF "$(PASS_MSG)"; then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)
